// File: src/sched_params.svh
`ifndef SCHED_PARAMS_SVH
`define SCHED_PARAMS_SVH

// scheduler geometry
`define NUM_PORTS       3
`define FIFOS_PER_PORT  3

// NUM_PORTS * FIFOS_PER_PORT
`define NUM_FIFOS       9

// index widths
// an element id holds either a fifo or a port index, so it takes the wider one
`define FIFO_ID_W       4
`define PORT_ID_W       2

// rank field of a queue element
`define RANK_W          5

// list depths
// level 1 holds at most one entry per fifo
`define L1_DEPTH        16

// level 2 holds at most one entry per port
`define L2_DEPTH        4

`endif

// File: src/pieo_pkg.sv
`include "sched_params.svh"

package pieo_pkg;

    // one queued entry, fifo or port index plus its rank
    typedef struct packed {
        logic [`FIFO_ID_W-1:0] id;
        logic [`RANK_W-1:0]    rank;
    } elem_t;

    // extract request
    // asks for the smallest rank whose id lies in [range_lo, range_hi]
    typedef struct packed {
        logic                  valid;
        logic [`FIFO_ID_W-1:0] range_lo;
        logic [`FIFO_ID_W-1:0] range_hi;
    } deq_req_t;

    // extract answer, one cycle after the request
    // found low means nothing in range, elem is then meaningless
    typedef struct packed {
        logic                  valid;
        logic                  found;
        elem_t                 elem;
    } deq_res_t;

endpackage

// File: src/sched_pkg.sv
`include "sched_params.svh"

package sched_pkg;

    // dequeue controller states
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        PORT_REQ  = 3'd1,
        PORT_WAIT = 3'd2,
        FIFO_REQ  = 3'd3,
        FIFO_WAIT = 3'd4,
        SEND      = 3'd5
    } state_t;

    // current grant, held while the packet is sent
    typedef struct packed {
        logic [`FIFO_ID_W-1:0] fifo_id;
        logic [`PORT_ID_W-1:0] port_id;
    } grant_t;

endpackage

// File: src/enq_tracker.sv
`timescale 1ns/100ps

`include "sched_params.svh"

module enq_tracker #(
    parameter int N     = `NUM_FIFOS,
    parameter int GROUP = `FIFOS_PER_PORT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [N-1:0]          valid,
    input  logic [N-1:0]          release_vec,
    output logic                  enq_valid,
    input  logic                  enq_ready,
    output pieo_pkg::elem_t       enq_elem,
    output logic [N-1:0]          enqueued,
    output logic [`NUM_PORTS-1:0] group_valid
);

    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    logic [N-1:0]     pending;
    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] cand;
    logic             cand_found;
    logic             xfer;

    // valid entries not yet handed to the list
    assign pending = valid & ~enqueued;

    // search upward from the last enqueued index, wrapping around
    always_comb begin : rr_search
        int idx;
        cand_found = 1'b0;
        cand       = rr_ptr;
        for (int k = 1; k <= N; k++) begin
            idx = (int'(rr_ptr) + k) % N;
            if (!cand_found && pending[idx]) begin
                cand_found = 1'b1;
                cand       = IDX_W'(idx);
            end
        end
    end

    assign enq_valid   = cand_found;
    assign enq_elem.id = `FIFO_ID_W'(cand);

    // fifo level ranks by index, port level keeps arrival order
    assign enq_elem.rank = (N == `NUM_FIFOS) ? `RANK_W'(cand) : '0;

    assign xfer = enq_valid & enq_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            enqueued <= '0;
            // so that the first search starts at index 0
            rr_ptr   <= IDX_W'(N - 1);
        end else begin
            enqueued <= (enqueued & ~release_vec) | (xfer ? (N'(1) << cand) : '0);
            if (xfer) begin
                rr_ptr <= cand;
            end
        end
    end

    // one bit per group with any entry enqueued
    always_comb begin : group_or
        for (int g = 0; g < `NUM_PORTS; g++) begin
            group_valid[g] = |enqueued[g*GROUP +: GROUP];
        end
    end

    // the controller only gives back what it took from this tracker
    release_targets_enqueued: assert property (@(posedge clk) disable iff (rst)
        (release_vec & ~enqueued) == '0);

endmodule

// File: src/pieo_list.sv
`timescale 1ns/100ps

`include "sched_params.svh"

module pieo_list #(
    parameter int DEPTH = `L1_DEPTH
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               enq_valid,
    output logic               enq_ready,
    input  pieo_pkg::elem_t    enq_elem,
    input  pieo_pkg::deq_req_t deq_req,
    output pieo_pkg::deq_res_t deq_res
);

    // slot 0 is the head with the smallest rank
    pieo_pkg::elem_t  slot [DEPTH];
    logic [DEPTH-1:0] slot_vld;

    // contents after the extract, then after the insert
    pieo_pkg::elem_t  mid_slot [DEPTH];
    logic [DEPTH-1:0] mid_vld;
    pieo_pkg::elem_t  nxt_slot [DEPTH];
    logic [DEPTH-1:0] nxt_vld;

    logic             hit_found;
    int               hit_idx;
    logic             ins_found;
    int               ins_idx;
    logic             do_deq;
    logic             do_enq;
    logic             dup_id;

    assign enq_ready = ~slot_vld[DEPTH-1];
    assign do_enq    = enq_valid & enq_ready;

    // first slot in range is the smallest eligible rank
    always_comb begin : find_hit
        hit_found = 1'b0;
        hit_idx   = 0;
        for (int k = 0; k < DEPTH; k++) begin
            if (!hit_found && slot_vld[k] && slot[k].id >= deq_req.range_lo
                && slot[k].id <= deq_req.range_hi) begin
                hit_found = 1'b1;
                hit_idx   = k;
            end
        end
    end

    assign do_deq = deq_req.valid & hit_found;

    // close the gap behind the extracted slot
    always_comb begin : close_gap
        for (int k = 0; k < DEPTH - 1; k++) begin
            if (do_deq && k >= hit_idx) begin
                mid_slot[k] = slot[k+1];
                mid_vld[k]  = slot_vld[k+1];
            end else begin
                mid_slot[k] = slot[k];
                mid_vld[k]  = slot_vld[k];
            end
        end
        mid_slot[DEPTH-1] = slot[DEPTH-1];
        mid_vld[DEPTH-1]  = slot_vld[DEPTH-1] & ~do_deq;
    end

    // insert behind every entry of equal or lower rank
    always_comb begin : find_slot
        ins_found = 1'b0;
        ins_idx   = DEPTH - 1;
        for (int k = 0; k < DEPTH; k++) begin
            if (!ins_found && (!mid_vld[k] || mid_slot[k].rank > enq_elem.rank)) begin
                ins_found = 1'b1;
                ins_idx   = k;
            end
        end
    end

    always_comb begin : open_gap
        nxt_slot[0] = (do_enq && ins_idx == 0) ? enq_elem : mid_slot[0];
        nxt_vld[0]  = mid_vld[0] | (do_enq && ins_idx == 0);
        for (int k = 1; k < DEPTH; k++) begin
            if (do_enq && k == ins_idx) begin
                nxt_slot[k] = enq_elem;
                nxt_vld[k]  = 1'b1;
            end else if (do_enq && k > ins_idx) begin
                nxt_slot[k] = mid_slot[k-1];
                nxt_vld[k]  = mid_vld[k-1];
            end else begin
                nxt_slot[k] = mid_slot[k];
                nxt_vld[k]  = mid_vld[k];
            end
        end
    end

    // id already queued
    always_comb begin : dup_check
        dup_id = 1'b0;
        for (int k = 0; k < DEPTH; k++) begin
            if (slot_vld[k] && slot[k].id == enq_elem.id) begin
                dup_id = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_vld <= '0;
            deq_res  <= '0;
        end else begin
            slot_vld      <= nxt_vld;
            deq_res.valid <= deq_req.valid;
            deq_res.found <= do_deq;
            deq_res.elem  <= slot[hit_idx];
        end
    end

    always_ff @(posedge clk) begin
        slot <= nxt_slot;
    end

    // valid slots stay packed at the head so the last slot shows full
    slots_packed_at_head: assert property (@(posedge clk) disable iff (rst)
        (slot_vld & (slot_vld + DEPTH'(1))) == '0);

    // the tracker must never hand over an entry twice
    no_duplicate_id: assert property (@(posedge clk) disable iff (rst)
        do_enq |-> !dup_id);

endmodule

// File: src/sched_fsm.sv
`timescale 1ns/100ps

`include "sched_params.svh"

module sched_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`NUM_FIFOS-1:0] fifo_tlast,
    output pieo_pkg::deq_req_t    l2_req,
    input  pieo_pkg::deq_res_t    l2_res,
    output pieo_pkg::deq_req_t    l1_req,
    input  pieo_pkg::deq_res_t    l1_res,
    output logic [`NUM_FIFOS-1:0] fifo_release,
    output logic [`NUM_PORTS-1:0] port_release,
    output logic [`FIFO_ID_W-1:0] sel_out,
    output logic                  en_out
);

    sched_pkg::state_t     state;
    sched_pkg::grant_t     grant;
    logic [`NUM_FIFOS-1:0] tlast_prev;
    logic [`NUM_FIFOS-1:0] tlast_rise;
    logic [`FIFO_ID_W-1:0] range_base;
    logic                  pkt_end;

    // end of packet is the rising edge of the granted fifo's tlast
    assign tlast_rise = fifo_tlast & ~tlast_prev;
    assign pkt_end    = tlast_rise[grant.fifo_id];

    // first fifo of the granted port
    assign range_base = `FIFO_ID_W'(grant.port_id * `FIFOS_PER_PORT);

    always_comb begin : req_drive
        l2_req          = '0;
        l2_req.valid    = (state == sched_pkg::PORT_REQ);
        l2_req.range_hi = `FIFO_ID_W'(`NUM_PORTS - 1);
        l1_req          = '0;
        l1_req.valid    = (state == sched_pkg::FIFO_REQ);
        l1_req.range_lo = range_base;
        l1_req.range_hi = range_base + `FIFO_ID_W'(`FIFOS_PER_PORT - 1);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= sched_pkg::IDLE;
            grant        <= '0;
            tlast_prev   <= '0;
            fifo_release <= '0;
            port_release <= '0;
        end else begin
            tlast_prev   <= fifo_tlast;
            fifo_release <= '0;
            port_release <= '0;
            case (state)
                sched_pkg::IDLE: begin
                    state <= sched_pkg::PORT_REQ;
                end
                sched_pkg::PORT_REQ: begin
                    state <= sched_pkg::PORT_WAIT;
                end
                sched_pkg::PORT_WAIT: begin
                    // nothing queued at level 2 so poll again
                    if (l2_res.valid && l2_res.found) begin
                        grant.port_id <= l2_res.elem.id[`PORT_ID_W-1:0];
                        state         <= sched_pkg::FIFO_REQ;
                    end else begin
                        state <= sched_pkg::IDLE;
                    end
                end
                sched_pkg::FIFO_REQ: begin
                    state <= sched_pkg::FIFO_WAIT;
                end
                sched_pkg::FIFO_WAIT: begin
                    if (l1_res.valid && l1_res.found) begin
                        grant.fifo_id <= l1_res.elem.id;
                        state         <= sched_pkg::SEND;
                    end else begin
                        // hand the port back so it can be queued again
                        port_release <= `NUM_PORTS'(1) << grant.port_id;
                        state        <= sched_pkg::IDLE;
                    end
                end
                sched_pkg::SEND: begin
                    if (pkt_end) begin
                        fifo_release <= `NUM_FIFOS'(1) << grant.fifo_id;
                        port_release <= `NUM_PORTS'(1) << grant.port_id;
                        state        <= sched_pkg::IDLE;
                    end
                end
                default: begin
                    state <= sched_pkg::IDLE;
                end
            endcase
        end
    end

    assign en_out  = (state == sched_pkg::SEND);
    assign sel_out = grant.fifo_id;

    // a port only reaches level 2 once one of its fifos sits in level 1
    l1_always_found: assert property (@(posedge clk) disable iff (rst)
        l1_res.valid |-> l1_res.found);

    // the level-1 list only hands out fifos of the granted port
    sel_in_granted_port: assert property (@(posedge clk) disable iff (rst)
        en_out |-> (sel_out >= range_base
            && sel_out <= range_base + `FIFO_ID_W'(`FIFOS_PER_PORT - 1)));

endmodule

// File: src/pieo_hier_sched.sv
`timescale 1ns/100ps

`include "sched_params.svh"

module pieo_hier_sched (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`NUM_FIFOS-1:0] fifo_tvalid,
    input  logic [`NUM_FIFOS-1:0] fifo_tlast,
    output logic [`FIFO_ID_W-1:0] sel_out,
    output logic                  en_out
);

    // ports with at least one fifo enqueued at level 1
    logic [`NUM_PORTS-1:0] port_valid;
    logic [`NUM_FIFOS-1:0] fifo_release;
    logic [`NUM_PORTS-1:0] port_release;

    logic                  l1_enq_valid;
    logic                  l1_enq_ready;
    pieo_pkg::elem_t       l1_enq_elem;
    pieo_pkg::deq_req_t    l1_req;
    pieo_pkg::deq_res_t    l1_res;

    logic                  l2_enq_valid;
    logic                  l2_enq_ready;
    pieo_pkg::elem_t       l2_enq_elem;
    pieo_pkg::deq_req_t    l2_req;
    pieo_pkg::deq_res_t    l2_res;

    // level 1, fifos ranked by index
    enq_tracker #(.N(`NUM_FIFOS), .GROUP(`FIFOS_PER_PORT)) u_fifo_trk (
        .clk(clk), .rst(rst),
        .valid(fifo_tvalid), .release_vec(fifo_release),
        .enq_valid(l1_enq_valid), .enq_ready(l1_enq_ready), .enq_elem(l1_enq_elem),
        .enqueued(), .group_valid(port_valid)
    );

    pieo_list #(.DEPTH(`L1_DEPTH)) u_l1_list (
        .clk(clk), .rst(rst),
        .enq_valid(l1_enq_valid), .enq_ready(l1_enq_ready), .enq_elem(l1_enq_elem),
        .deq_req(l1_req), .deq_res(l1_res)
    );

    // level 2, ports in arrival order
    enq_tracker #(.N(`NUM_PORTS), .GROUP(1)) u_port_trk (
        .clk(clk), .rst(rst),
        .valid(port_valid), .release_vec(port_release),
        .enq_valid(l2_enq_valid), .enq_ready(l2_enq_ready), .enq_elem(l2_enq_elem),
        .enqueued(), .group_valid()
    );

    pieo_list #(.DEPTH(`L2_DEPTH)) u_l2_list (
        .clk(clk), .rst(rst),
        .enq_valid(l2_enq_valid), .enq_ready(l2_enq_ready), .enq_elem(l2_enq_elem),
        .deq_req(l2_req), .deq_res(l2_res)
    );

    sched_fsm u_fsm (
        .clk(clk), .rst(rst),
        .fifo_tlast(fifo_tlast),
        .l2_req(l2_req), .l2_res(l2_res),
        .l1_req(l1_req), .l1_res(l1_res),
        .fifo_release(fifo_release), .port_release(port_release),
        .sel_out(sel_out), .en_out(en_out)
    );

endmodule

// File: tb/tb_pieo_hier_sched.sv
`timescale 1ns/100ps

`include "sched_params.svh"

module tb_pieo_hier_sched;

    localparam int NUM_ROWS   = 11;
    localparam int RST_CYCLES = 4;
    localparam int GAP_CYCLES = 3;

    // one stimulus row where len 0 draws a random length per packet
    typedef struct packed {
        logic [`NUM_FIFOS-1:0] mask;
        logic [2:0]            len;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic [`NUM_FIFOS-1:0] fifo_tvalid;
    logic [`NUM_FIFOS-1:0] fifo_tlast;
    logic [`FIFO_ID_W-1:0] sel_out;
    logic                  en_out;

    row_t        rows [NUM_ROWS];
    int          exp_q [$];
    int          err_count;
    int          check_count;
    int          cycle_count;
    int          cycle_limit;
    int          last_idx;
    logic [31:0] rng_state;

    pieo_hier_sched uut (
        .clk(clk), .rst(rst),
        .fifo_tvalid(fifo_tvalid), .fifo_tlast(fifo_tlast),
        .sel_out(sel_out), .en_out(en_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: no progress after %0d cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_table();
        rows[0]  = '{mask: 9'h001, len: 3'd2};
        rows[1]  = '{mask: 9'h010, len: 3'd0};
        rows[2]  = '{mask: 9'h1c0, len: 3'd1};
        rows[3]  = '{mask: 9'h028, len: 3'd3};
        rows[4]  = '{mask: 9'h007, len: 3'd0};
        rows[5]  = '{mask: 9'h096, len: 3'd1};
        rows[6]  = '{mask: 9'h1ff, len: 3'd0};
        rows[7]  = '{mask: 9'h060, len: 3'd2};
        rows[8]  = '{mask: 9'h100, len: 3'd4};
        rows[9]  = '{mask: 9'h049, len: 3'd0};
        rows[10] = '{mask: 9'h10c, len: 3'd5};
    endtask

    // ports queue in order of first arrival
    // a port with fifos left rejoins at the back after each packet
    task automatic build_expected(input logic [`NUM_FIFOS-1:0] mask);
        logic [`NUM_FIFOS-1:0] left;
        logic [`NUM_PORTS-1:0] seen;
        int                    port_q [$];
        int                    idx;
        int                    port;
        int                    picked;
        logic                  found;
        exp_q.delete();
        left = mask;
        seen = '0;
        // level-1 arrival order, upward from the last enqueued index
        for (int k = 1; k <= `NUM_FIFOS; k++) begin
            idx = (last_idx + k) % `NUM_FIFOS;
            if (mask[idx]) begin
                port = idx / `FIFOS_PER_PORT;
                if (!seen[port]) begin
                    seen[port] = 1'b1;
                    port_q.push_back(port);
                end
            end
        end
        for (int k = 1; k <= `NUM_FIFOS; k++) begin
            if (mask[(last_idx + k) % `NUM_FIFOS]) begin
                idx = (last_idx + k) % `NUM_FIFOS;
            end
        end
        if (mask != '0) begin
            last_idx = idx;
        end
        while (port_q.size() > 0) begin
            port   = port_q.pop_front();
            found  = 1'b0;
            picked = 0;
            // lowest index wins within a port
            for (int f = port * `FIFOS_PER_PORT; f < (port + 1) * `FIFOS_PER_PORT; f++) begin
                if (!found && left[f]) begin
                    found  = 1'b1;
                    picked = f;
                end
            end
            left[picked] = 1'b0;
            exp_q.push_back(picked);
            if (|left[port*`FIFOS_PER_PORT +: `FIFOS_PER_PORT]) begin
                port_q.push_back(port);
            end
        end
    endtask

    task automatic run_row(input row_t row);
        int                    n_pkts;
        int                    pkt_len;
        logic [`FIFO_ID_W-1:0] held_sel;
        build_expected(row.mask);
        n_pkts      = exp_q.size();
        fifo_tvalid = row.mask;
        for (int p = 0; p < n_pkts; p++) begin
            while (en_out !== 1'b1) begin
                next_cycle();
            end
            held_sel = sel_out;
            compare(32'(row.mask[held_sel]), 32'd1, "grant of a fifo outside the row mask");
            compare(32'(held_sel), 32'(exp_q[p]), "grant order");
            if (row.len == 3'd0) begin
                rng_state = xorshift32(rng_state);
                pkt_len   = int'(rng_state[2:0]);
            end else begin
                pkt_len = int'(row.len);
            end
            repeat (pkt_len) begin
                next_cycle();
                compare(32'(en_out), 32'd1, "en_out dropped before tlast");
                compare(32'(sel_out), 32'(held_sel), "sel_out changed while sending");
            end
            fifo_tlast[held_sel]  = 1'b1;
            fifo_tvalid[held_sel] = 1'b0;
            next_cycle();
            compare(32'(en_out), 32'd0, "en_out one cycle after tlast");
            fifo_tlast[held_sel] = 1'b0;
        end
        repeat (GAP_CYCLES) begin
            next_cycle();
            compare(32'(en_out), 32'd0, "extra grant after the row");
        end
    endtask

    initial begin : main
        rst         = 1'b1;
        fifo_tvalid = '0;
        fifo_tlast  = '0;
        err_count   = 0;
        check_count = 0;
        cycle_count = 0;
        rng_state   = 32'he09a5e11;
        // first search starts at index 0
        last_idx    = `NUM_FIFOS - 1;
        load_table();
        cycle_limit = RST_CYCLES;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += (((rows[r].len == 3'd0) ? 7 : int'(rows[r].len)) + 12)
                * $countones(rows[r].mask);
        end
        repeat (RST_CYCLES) begin
            next_cycle();
            compare(32'(en_out), 32'd0, "en_out during reset");
        end
        rst = 1'b0;
        next_cycle();
        compare(32'(en_out), 32'd0, "en_out one cycle after reset");
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+src
src/pieo_pkg.sv
src/sched_pkg.sv
src/enq_tracker.sv
src/pieo_list.sv
src/sched_fsm.sv
src/pieo_hier_sched.sv
tb/tb_pieo_hier_sched.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the scheduler testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_pieo_hier_sched \
    -o tb_pieo_hier_sched

# keep the output in memory and search it for the pass line
sim_out=$(./obj_dir/tb_pieo_hier_sched)
echo "$sim_out"

if echo "$sim_out" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi
